//--- hw/rf_bank_settings.svh
// Build settings for the power-gated register file bank
// Depth and width of one macro wrapper, wake delay of its
// power sequencer and the word that lost contents read as

`ifndef RF_BANK_SETTINGS_SVH
`define RF_BANK_SETTINGS_SVH

// Words held by one wrapper
`define RF_DEPTH 16

// Bits per word
`define RF_WIDTH 24

// Cycles of rclk from a low enable input to a low enable output
`define RF_WAKE_CYCLES 4

// Pattern returned by a word whose contents were lost to power gating
`define RF_POISON 24'hBAD0DE

`endif

//--- hw/rf_bank_pkg.sv
// Shared types for the register file bank
// Word address inside one wrapper, bank address with the
// wrapper select on top, and the data word

package rf_bank_pkg;

    // ----------------------------------------
    // Addresses
    // ----------------------------------------

    // Selects one of the 16 words in a wrapper
    typedef logic [3:0] rf_addr_t;

    // Bank address across both wrappers
    // The top bit picks the wrapper and the rest is the word address
    typedef logic [4:0] bank_addr_t;

    // ----------------------------------------
    // Data
    // ----------------------------------------

    // One stored word
    typedef logic [23:0] rf_data_t;

endpackage

//--- hw/rf_array.sv
// Behavioral storage of one power-gated wrapper
// Write port in wclk gated by the power state seen in wclk,
// registered read port in rclk, and loss of contents while
// the wrapper has no power

`timescale 1ns/1ps
`include "rf_bank_settings.svh"

module rf_array
    import rf_bank_pkg::*;
(
     input  logic     wclk
    ,input  logic     rclk
    ,input  logic     rst
    ,input  logic     we
    ,input  logic     wen_ok
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,input  logic     pwr_ready
    ,output rf_data_t rdata
);

    localparam rf_data_t poison_word = `RF_WIDTH'(`RF_POISON);

    // Storage cells
    rf_data_t mem [`RF_DEPTH];

    // ----------------------------------------
    // Write side
    // ----------------------------------------

    // While the wclk view of power is low the cells hold no charge
    // Every word is overwritten with the poison pattern so that a word
    // not rewritten after wake-up reads back as lost
    // A write only lands once power is seen as ready in wclk
    always_ff @(posedge wclk) begin
        if (!wen_ok) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                mem[i] <= poison_word;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ----------------------------------------
    // Read side
    // ----------------------------------------

    // The output register loads only on a read strobe and holds otherwise
    // An unpowered array has nothing to sense, so the read returns poison
    // even in the short window before the write side sees the power drop
    always_ff @(posedge rclk) begin
        if (rst) begin
            rdata <= '0;
        end else if (re) begin
            if (pwr_ready) begin
                rdata <= mem[raddr];
            end else begin
                rdata <= poison_word;
            end
        end
    end

endmodule

//--- hw/rf_pwr_seq.sv
// Power sequencer of one wrapper
// Counts the wake delay after the power enable goes low and
// then passes the enable on to the next wrapper in the chain
// Also gives the power ready level used by the array

`timescale 1ns/1ps
`include "rf_bank_settings.svh"

module rf_pwr_seq (
     input  logic rclk
    ,input  logic rst
    ,input  logic pwr_enable_b_in
    ,output logic pwr_enable_b_out
    ,output logic pwr_ready
);

    // Counter wide enough to hold the full wake delay
    localparam int cnt_w = $clog2(`RF_WAKE_CYCLES + 1);
    localparam logic [cnt_w-1:0] wake_count = cnt_w'(`RF_WAKE_CYCLES);

    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] cnt_nxt;

    // ----------------------------------------
    // Wake counter
    // ----------------------------------------

    // Counts up while the enable input is low and stops at the wake delay
    // The saturated value keeps the wrapper awake until power is removed
    always_comb begin
        cnt_nxt = cnt;
        if (cnt != wake_count) begin
            cnt_nxt = cnt + cnt_w'(1);
        end
    end

    // ----------------------------------------
    // Enable chain and ready level
    // ----------------------------------------

    // The first edge that samples the input low moves the count to one
    // The edge that brings it to the wake delay drops the enable output,
    // which is exactly RF_WAKE_CYCLES edges after the first low sample
    // A high input restarts the count and drops power at the next edge
    always_ff @(posedge rclk) begin
        if (rst || pwr_enable_b_in) begin
            cnt              <= '0;
            pwr_enable_b_out <= 1'b1;
            pwr_ready        <= 1'b0;
        end else begin
            cnt              <= cnt_nxt;
            pwr_enable_b_out <= (cnt_nxt != wake_count);
            pwr_ready        <= (cnt_nxt == wake_count);
        end
    end

    // Enable output low and ready high always move together
    // The ready level stays local to the wrapper while the
    // enable output goes on down the chain

endmodule

//--- hw/rf_pg_16x24.sv
// Power-gated 16x24 two-port register file macro wrapper
// Reset synchronizer into rclk, crossing of the power ready
// level into wclk, isolation clamp on the read data, and the
// power sequencer and storage array

`timescale 1ns/1ps

module rf_pg_16x24
    import rf_bank_pkg::*;
(
     input  logic     wclk
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata

    ,input  logic     rclk
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,output rf_data_t rdata

    ,input  logic     rst

    // Power gating controller
    ,input  logic     pgcb_isol_en
    ,input  logic     pwr_enable_b_in
    ,output logic     pwr_enable_b_out
);

    logic     rst_meta;
    logic     rst_sync;
    logic     pwr_ready;
    logic     pwr_ready_meta;
    logic     pwr_ready_w;
    rf_data_t rdata_arr;

    // ----------------------------------------
    // Reset synchronizer
    // ----------------------------------------

    // Two rclk flops bring the reset into the read clock domain
    // The sequencer and read register see it two edges late
    always_ff @(posedge rclk) begin
        rst_meta <= rst;
        rst_sync <= rst_meta;
    end

    // ----------------------------------------
    // Power ready into wclk
    // ----------------------------------------

    // Writes are allowed only once the wclk side sees the wrapper awake
    // The level lags pwr_ready by two wclk edges in each direction
    always_ff @(posedge wclk) begin
        if (rst) begin
            pwr_ready_meta <= 1'b0;
            pwr_ready_w    <= 1'b0;
        end else begin
            pwr_ready_meta <= pwr_ready;
            pwr_ready_w    <= pwr_ready_meta;
        end
    end

    // ----------------------------------------
    // Power sequencer and storage
    // ----------------------------------------

    rf_pwr_seq u_pwr_seq (
         .rclk             (rclk)
        ,.rst              (rst_sync)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr_ready        (pwr_ready)
    );

    rf_array u_array (
         .wclk      (wclk)
        ,.rclk      (rclk)
        ,.rst       (rst_sync)
        ,.we        (we)
        ,.wen_ok    (pwr_ready_w)
        ,.waddr     (waddr)
        ,.wdata     (wdata)
        ,.re        (re)
        ,.raddr     (raddr)
        ,.pwr_ready (pwr_ready)
        ,.rdata     (rdata_arr)
    );

    // Isolation holds the outputs at a known zero while the domain may float
    assign rdata = pgcb_isol_en ? '0 : rdata_arr;

endmodule

//--- hw/rf_bank_32x24.sv
// Power-gated 32x24 two-port register file bank
// Two 16x24 wrappers selected by the top address bit, with
// the power enables chained so wrapper 1 wakes after wrapper 0,
// and the read data steered from the wrapper that answered

`timescale 1ns/1ps

module rf_bank_32x24
    import rf_bank_pkg::*;
(
     input  logic       wclk
    ,input  logic       we
    ,input  bank_addr_t waddr
    ,input  rf_data_t   wdata

    ,input  logic       rclk
    ,input  logic       re
    ,input  bank_addr_t raddr
    ,output rf_data_t   rdata

    ,input  logic       rst

    // Power gating controller
    ,input  logic       pgcb_isol_en
    ,input  logic       pwr_enable_b_in
    ,output logic       pwr_enable_b_out
);

    localparam int num_banks = 2;
    // Position of the wrapper select bit in a bank address
    localparam int bank_bit = $bits(bank_addr_t) - 1;

    // Power enable chain with one tap before each wrapper and one at the end
    logic [num_banks:0] pwr_chain;
    rf_data_t           bank_rdata [num_banks];
    logic               rbank_q;

    assign pwr_chain[0]     = pwr_enable_b_in;
    assign pwr_enable_b_out = pwr_chain[num_banks];

    // ----------------------------------------
    // Wrappers
    // ----------------------------------------

    // Each wrapper sees the strobes only for its own half of the address space
    // and takes its power enable from the wrapper before it
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        logic bank_we;
        logic bank_re;

        assign bank_we = we && (waddr[bank_bit] == 1'(b));
        assign bank_re = re && (raddr[bank_bit] == 1'(b));

        rf_pg_16x24 u_rf (
             .wclk             (wclk)
            ,.we               (bank_we)
            ,.waddr            (waddr[bank_bit-1:0])
            ,.wdata            (wdata)
            ,.rclk             (rclk)
            ,.re               (bank_re)
            ,.raddr            (raddr[bank_bit-1:0])
            ,.rdata            (bank_rdata[b])
            ,.rst              (rst)
            ,.pgcb_isol_en     (pgcb_isol_en)
            ,.pwr_enable_b_in  (pwr_chain[b])
            ,.pwr_enable_b_out (pwr_chain[b+1])
        );
    end

    // ----------------------------------------
    // Read data select
    // ----------------------------------------

    // The wrapper that took the read is remembered for the cycle its data appears
    // Between reads the select holds so rdata keeps the last answer
    always_ff @(posedge rclk) begin
        if (rst) begin
            rbank_q <= 1'b0;
        end else if (re) begin
            rbank_q <= raddr[bank_bit];
        end
    end

    assign rdata = bank_rdata[rbank_q];

endmodule

//--- dv/rf_bank_sva.sv
// Concurrent assertions on the register file bank
// Power enable during reset, response of the enable chain
// to a power-down request, and the isolation clamp on rdata

`timescale 1ns/1ps

module rf_bank_sva
    import rf_bank_pkg::*;
(
     input  logic     rclk
    ,input  logic     rst
    ,input  logic     pgcb_isol_en
    ,input  logic     pwr_enable_b_in
    ,input  logic     pwr_enable_b_out
    ,input  rf_data_t rdata
);

    // ----------------------------------------
    // Power enable chain
    // ----------------------------------------

    // The first edge of reset only starts the enable chain, so the
    // check begins once reset has been seen on two edges in a row
    a_off_in_reset : assert property (@(posedge rclk)
        (rst && $past(rst)) |-> pwr_enable_b_out)
        else $error("enable output low during reset");

    // Each wrapper drops its enable one edge after seeing a high input,
    // so two wrappers in a chain take at most two edges
    a_off_follows : assert property (@(posedge rclk)
        pwr_enable_b_in |-> ##[0:2] pwr_enable_b_out)
        else $error("enable output slow to follow a power-down");

    // ----------------------------------------
    // Isolation
    // ----------------------------------------

    // The clamp is combinational and wins over any stored word
    a_iso_zero : assert property (@(posedge rclk)
        pgcb_isol_en |-> (rdata == '0))
        else $error("rdata not clamped while isolated");

endmodule

bind rf_bank_32x24 rf_bank_sva u_sva (
     .rclk             (rclk)
    ,.rst              (rst)
    ,.pgcb_isol_en     (pgcb_isol_en)
    ,.pwr_enable_b_in  (pwr_enable_b_in)
    ,.pwr_enable_b_out (pwr_enable_b_out)
    ,.rdata            (rdata)
);

//--- dv/tb_rf_bank.sv
// Testbench for the power-gated 32x24 register file bank
// Clock and reset, LFSR data source, a table of operations with
// expected values built from a shadow model, and compare tasks

`timescale 1ns/1ps
`include "rf_bank_settings.svh"

module tb_rf_bank
    import rf_bank_pkg::*;
();

    typedef enum logic [2:0] {OP_WAKE, OP_SLEEP, OP_WRITE, OP_READ, OP_ISO_ON, OP_ISO_OFF} op_t;

    localparam int num_words = 2 * `RF_DEPTH;
    localparam int wake_limit = 2 * `RF_WAKE_CYCLES + 4;
    localparam rf_data_t poison_word = `RF_WIDTH'(`RF_POISON);

    logic       clk = 1'b0;
    logic       rst;
    logic       we;
    bank_addr_t waddr;
    rf_data_t   wdata;
    logic       re;
    bank_addr_t raddr;
    logic       pgcb_isol_en;
    logic       pwr_enable_b_in;
    rf_data_t   rdata;
    logic       pwr_enable_b_out;

    // Operation table and the shadow model that fills in expected values
    op_t        tbl_op [$];
    bank_addr_t tbl_addr [$];
    rf_data_t   tbl_data [$];
    rf_data_t   tbl_exp [$];
    rf_data_t   shadow [num_words];
    logic       powered;
    rf_data_t   last_rd;
    logic [15:0] lfsr_state = 16'd53978;

    // One source for both clocks
    always #5 clk = ~clk;

    rf_bank_32x24 dut (
         .wclk             (clk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (clk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.rst              (rst)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Galois LFSR with taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per data bit
    function rf_data_t rand_word();
        rf_data_t w;
        w = '0;
        for (int i = 0; i < $bits(rf_data_t); i++) begin
            w = {w[$bits(rf_data_t)-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_data(input string name, input rf_data_t got, input rf_data_t exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_pwr(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Waits on falling edges until the enable output reaches the level
    task automatic wait_pwr(input logic level, input int limit);
        int n;
        for (n = 0; n < limit && pwr_enable_b_out !== level; n++) begin
            @(negedge clk);
        end
        if (pwr_enable_b_out !== level) begin
            fail_now($sformatf("Timeout: power enable output did not reach %0d in %0d cycles",
                level, limit));
        end
    endtask

    // Appends one step and works out its expected value from the bank rules
    task automatic add_step(input op_t op, input bank_addr_t addr, input rf_data_t data);
        rf_data_t exp;
        exp = '0;
        case (op)
            OP_WAKE: powered = 1'b1;
            OP_SLEEP: begin
                powered = 1'b0;
                for (int i = 0; i < num_words; i++) shadow[i] = poison_word;
            end
            OP_WRITE: if (powered) shadow[addr] = data;
            OP_READ: begin
                exp = shadow[addr];
                last_rd = exp;
            end
            OP_ISO_OFF: exp = last_rd;
            default: exp = '0;
        endcase
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_exp.push_back(exp);
    endtask

    // Drives one step on falling edges and checks its result
    task automatic apply_step(input int i);
        case (tbl_op[i])
            OP_WAKE: begin
                // The wake bound counts from the edge that drives the input low
                pwr_enable_b_in = 1'b0;
                wait_pwr(1'b0, wake_limit);
                // Let the ready level cross into the write clock
                repeat (3) @(negedge clk);
            end
            OP_SLEEP: begin
                // Each wrapper in the chain adds one cycle
                pwr_enable_b_in = 1'b1;
                wait_pwr(1'b1, 2);
                repeat (3) @(negedge clk);
                check_pwr("pwr_enable_b_out", pwr_enable_b_out, 1'b1);
            end
            OP_WRITE: begin
                we    = 1'b1;
                waddr = tbl_addr[i];
                wdata = tbl_data[i];
                @(negedge clk);
                we = 1'b0;
            end
            OP_READ: begin
                re    = 1'b1;
                raddr = tbl_addr[i];
                @(negedge clk);
                re = 1'b0;
                check_data("rdata", rdata, tbl_exp[i]);
            end
            OP_ISO_ON: begin
                pgcb_isol_en = 1'b1;
                @(negedge clk);
                check_data("rdata", rdata, tbl_exp[i]);
            end
            default: begin
                pgcb_isol_en = 1'b0;
                @(negedge clk);
                check_data("rdata", rdata, tbl_exp[i]);
            end
        endcase
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        rst             = 1'b1;
        we              = 1'b0;
        waddr           = '0;
        wdata           = '0;
        re              = 1'b0;
        raddr           = '0;
        pgcb_isol_en    = 1'b0;
        pwr_enable_b_in = 1'b1;
        powered         = 1'b0;
        last_rd         = '0;
        for (int i = 0; i < num_words; i++) shadow[i] = poison_word;

        // Wake, fill every word and read it all back
        add_step(OP_WAKE, '0, '0);
        for (int a = 0; a < num_words; a++) add_step(OP_WRITE, bank_addr_t'(a), rand_word());
        for (int a = 0; a < num_words; a++) add_step(OP_READ, bank_addr_t'(a), '0);
        // A write while asleep is dropped and the lost contents read as poison
        add_step(OP_SLEEP, '0, '0);
        add_step(OP_WRITE, 5'd5, rand_word());
        add_step(OP_WAKE, '0, '0);
        for (int a = 0; a < num_words; a++) add_step(OP_READ, bank_addr_t'(a), '0);
        // Isolation clamps the answer and releasing it shows the word again
        add_step(OP_WRITE, 5'd19, rand_word());
        add_step(OP_READ, 5'd19, '0);
        add_step(OP_ISO_ON, '0, '0);
        add_step(OP_ISO_OFF, '0, '0);

        repeat (5) @(negedge clk);
        rst = 1'b0;
        // Reset still travels through the synchronizer
        repeat (3) @(negedge clk);
        check_pwr("pwr_enable_b_out", pwr_enable_b_out, 1'b1);
        check_data("rdata", rdata, '0);

        for (int i = 0; i < tbl_op.size(); i++) begin
            apply_step(i);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- rf_bank.f
+incdir+hw
hw/rf_bank_pkg.sv
hw/rf_array.sv
hw/rf_pwr_seq.sv
hw/rf_pg_16x24.sv
hw/rf_bank_32x24.sv
dv/rf_bank_sva.sv
dv/tb_rf_bank.sv

//--- run.sh
#!/bin/sh
# Compile and run the register file bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rf_bank -f rf_bank.f -o sim_rf_bank

out=$(./obj_dir/sim_rf_bank 2>&1 || true)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi
